//--- src.f
hw/msx_tape_pkg.sv
hw/ioctl_if.sv
hw/clock_enables.sv
hw/tape_control.sv
hw/cas_ram.sv
hw/cas_player.sv
hw/msx_tape_top.sv
bench/tb_msx_tape.sv

//--- Bender.yml
package:
  name: msx_tape

sources:
  # Design, package first
  - files:
      - hw/msx_tape_pkg.sv
      - hw/ioctl_if.sv
      - hw/clock_enables.sv
      - hw/tape_control.sv
      - hw/cas_ram.sv
      - hw/cas_player.sv
      - hw/msx_tape_top.sv

  # Simulation only
  - target: test
    files:
      - bench/tb_msx_tape.sv

//--- bench/tb_msx_tape.sv
// Testbench for the MSX tape path with clock, reset, LCG stimulus, waveform model, checks and timeout
`default_nettype none

module tb_msx_tape;

	timeunit 1ns;
	timeprecision 100ps;

	import msx_tape_pkg::*;

	// Fast tape so a whole image plays in a few thousand cycles
	localparam int HS       = 3;
	localparam int HALF_CYC = HS * CE_DIV;

	logic        CLK_VIDEO;
	logic        rst_n;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic        status_src_adc;
	logic        status_rewind;
	logic        motor;
	logic        adc_bit;
	logic        adc_active;
	logic        ce_10m7;
	logic        ce_5m3;
	logic        cas_audio_in;
	logic        playing;

	bit [31:0]   seed = 32'ha1d2_7b26;
	logic [7:0]  img [0:15];
	int          len_t [0:2];
	int          exp_q [$];
	int          n_edges;
	int          edge_idx;
	int          run_cnt;
	int          last_edge;
	logic        mon_on = 1'b0;
	logic        prev_audio = 1'b0;
	int          err_cnt = 0;
	int          test_err0 = 0;
	int          n_tests = 0;
	int          n_failed = 0;
	int          cyc_cnt = 0;
	int          cyc_limit = 0;
	int          n_pause;
	logic        d0;
	logic        d1;
	logic        b;
	logic        a;

	msx_tape_top #(
		.HALF_SHORT (HS)
	) i_msx_tape_top (
		.CLK_VIDEO      (CLK_VIDEO),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.status_src_adc (status_src_adc),
		.status_rewind  (status_rewind),
		.motor          (motor),
		.adc_bit        (adc_bit),
		.adc_active     (adc_active),
		.ce_10m7        (ce_10m7),
		.ce_5m3         (ce_5m3),
		.cas_audio_in   (cas_audio_in),
		.playing        (playing)
	);

	initial begin
		CLK_VIDEO = 1'b0;
		forever #5 CLK_VIDEO = ~CLK_VIDEO;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Upper LCG bits are the better ones
	function automatic int unsigned next_rand(input int unsigned range);
		seed = seed * 32'd1664525 + 32'd1013904223;
		return (seed >> 8) % range;
	endfunction

	task automatic report_fail(input string msg);
		$display("Fail %0t: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (err_cnt == test_err0) begin
			$display("%s: passed", name);
		end else begin
			n_failed++;
			$display("%s: failed with %0d errors", name, err_cnt - test_err0);
		end
		test_err0 = err_cnt;
	endtask

	// Random bytes plus the expected edge intervals in CLK_VIDEO cycles
	// Start bit 0, eight data bits LSB first, stop bits 1
	function automatic void make_image(input int n);
		logic bit_v;
		exp_q.delete();
		for (int i = 0; i < n; i++) begin
			img[i] = 8'(next_rand(256));
			for (int f = 0; f < 9 + STOP_BITS; f++) begin
				if (f == 0)
					bit_v = 1'b0;
				else if (f <= 8)
					bit_v = img[i][f-1];
				else
					bit_v = 1'b1;
				// High tone edge every half, low tone every second half
				if (bit_v)
					repeat (BIT_HALVES) exp_q.push_back(HALF_CYC);
				else
					repeat (BIT_HALVES / 2) exp_q.push_back(2 * HALF_CYC);
			end
		end
		n_edges = exp_q.size();
		// First edge only marks the reference point
		void'(exp_q.pop_front());
	endfunction

	// One byte every other cycle with random data when not from the image
	task automatic load_bytes(input logic [7:0] idx, input int n, input bit from_img);
		@(posedge CLK_VIDEO);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		for (int i = 0; i < n; i++) begin
			@(posedge CLK_VIDEO);
			ioctl_wr   <= 1'b1;
			ioctl_addr <= 25'(i);
			ioctl_dout <= from_img ? img[i] : 8'(next_rand(256));
			@(posedge CLK_VIDEO);
			ioctl_wr   <= 1'b0;
		end
		@(posedge CLK_VIDEO);
		ioctl_download <= 1'b0;
		@(posedge CLK_VIDEO);
	endtask

	task automatic arm_monitor;
		@(posedge CLK_VIDEO);
		edge_idx  = 0;
		run_cnt   = 0;
		last_edge = 0;
		mon_on   <= 1'b1;
	endtask

	task automatic wait_play_end;
		while (edge_idx < n_edges)
			@(posedge CLK_VIDEO);
		repeat (2) @(posedge CLK_VIDEO);
		assert (!playing) else report_fail("playing still high after the last stop bit");
		repeat (100) @(posedge CLK_VIDEO);
		assert (edge_idx == n_edges)
			else report_fail($sformatf("saw %0d edges, expected %0d", edge_idx, n_edges));
		motor  <= 1'b0;
		mon_on <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Edge monitor counting time only while motor runs
	////////////////////////////////////////////////////////////

	always @(posedge CLK_VIDEO) begin
		if (mon_on) begin
			if (motor)
				run_cnt++;
			if (cas_audio_in != prev_audio) begin
				assert (motor) else report_fail("edge on cas_audio_in while motor is low");
				assert (edge_idx < n_edges) else report_fail("edge after the end of the image");
				// Output starts low, so the first edge rises
				if (edge_idx == 0) begin
					assert (cas_audio_in) else report_fail("first edge is not rising");
				end else if (edge_idx < n_edges) begin
					assert (run_cnt - last_edge == exp_q[edge_idx-1])
						else report_fail($sformatf("edge %0d interval %0d, expected %0d",
							edge_idx, run_cnt - last_edge, exp_q[edge_idx-1]));
				end
				last_edge = run_cnt;
				edge_idx++;
			end
		end
		prev_audio = cas_audio_in;
	end

	// Watchdog
	always @(posedge CLK_VIDEO) begin
		cyc_cnt++;
		if (cyc_cnt > cyc_limit) begin
			$display("Timeout, the run did not finish within %0d cycles", cyc_limit);
			$display("Test FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		rst_n          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = 8'd0;
		status_src_adc = 1'b0;
		status_rewind  = 1'b0;
		motor          = 1'b0;
		adc_bit        = 1'b0;
		adc_active     = 1'b0;
		for (int t = 0; t < 3; t++)
			len_t[t] = 4 + next_rand(9);
		// Full plays with the rewind image counted twice plus 6000 for loads, pauses and checks
		cyc_limit = 2 * ((len_t[0] + len_t[1] + 2 * len_t[2]) * (9 + STOP_BITS)
			* BIT_HALVES * HS * CE_DIV + 6000);

		// Strobes stay low in reset and then come every 4 and 8 cycles from cycle 1
		repeat (16) begin
			@(posedge CLK_VIDEO);
			assert (!ce_10m7 && !ce_5m3) else report_fail("clock enable high during reset");
		end
		rst_n <= 1'b1;
		begin : clk_check
			int last10;
			int last5;
			last10 = -1;
			last5  = -1;
			for (int c = 0; c < 64; c++) begin
				@(posedge CLK_VIDEO);
				if (ce_5m3) begin
					assert (ce_10m7) else report_fail("ce_5m3 without ce_10m7");
					assert (last5 < 0 ? c == 1 : c - last5 == 8)
						else report_fail($sformatf("ce_5m3 at cycle %0d", c));
					last5 = c;
				end
				if (ce_10m7) begin
					assert (last10 < 0 ? c == 1 : c - last10 == 4)
						else report_fail($sformatf("ce_10m7 at cycle %0d", c));
					last10 = c;
				end
			end
			assert (last5 >= 0 && last10 >= 0) else report_fail("no clock enable strobes seen");
		end
		end_test("clock enables");

		// Foreign index writes land between download and playback
		make_image(len_t[0]);
		load_bytes({2'b00, CAS_INDEX}, len_t[0], 1'b1);
		load_bytes(8'(3 + next_rand(60)), len_t[0] + 4, 1'b0);
		assert (playing) else report_fail("playing low after a CAS download");
		arm_monitor();
		motor <= 1'b1;
		wait_play_end();
		end_test("download and play");

		// Motor drops halfway between ticks and pauses for whole tick periods
		make_image(len_t[1]);
		load_bytes({2'b01, CAS_INDEX}, len_t[1], 1'b1);
		arm_monitor();
		motor   <= 1'b1;
		n_pause  = 0;
		while (edge_idx < n_edges && n_pause < 4) begin
			repeat (100 + next_rand(300)) @(posedge CLK_VIDEO);
			while (!(ce_10m7 && !ce_5m3))
				@(posedge CLK_VIDEO);
			motor <= 1'b0;
			repeat (8 * (1 + next_rand(4))) @(posedge CLK_VIDEO);
			motor <= 1'b1;
			n_pause++;
		end
		wait_play_end();
		end_test("motor pauses");

		// Rewind somewhere inside the image and play the whole image again
		make_image(len_t[2]);
		load_bytes({2'b00, CAS_INDEX}, len_t[2], 1'b1);
		arm_monitor();
		motor <= 1'b1;
		repeat (500 + next_rand(2000)) @(posedge CLK_VIDEO);
		mon_on        <= 1'b0;
		status_rewind <= 1'b1;
		@(posedge CLK_VIDEO);
		status_rewind <= 1'b0;
		repeat (3) @(posedge CLK_VIDEO);
		assert (!cas_audio_in && playing) else report_fail("output not low and playing after rewind");
		arm_monitor();
		wait_play_end();
		end_test("rewind");

		// Output follows the gated ADC bit one register later
		@(posedge CLK_VIDEO);
		status_src_adc <= 1'b1;
		repeat (4) @(posedge CLK_VIDEO);
		d0 = 1'b0;
		d1 = 1'b0;
		for (int i = 0; i < 200; i++) begin
			@(posedge CLK_VIDEO);
			assert (cas_audio_in == d1)
				else report_fail($sformatf("ADC output %0b, expected %0b", cas_audio_in, d1));
			d1 = d0;
			b  = 1'(next_rand(2));
			a  = (next_rand(4) != 0);
			d0 = b & a;
			adc_bit    <= b;
			adc_active <= a;
		end
		adc_bit    <= 1'b1;
		adc_active <= 1'b1;
		repeat (3) @(posedge CLK_VIDEO);
		assert (cas_audio_in) else report_fail("ADC output not high with bit and activity set");
		status_src_adc <= 1'b0;
		repeat (3) @(posedge CLK_VIDEO);
		// Player level after a full image is the parity of its edges
		assert (cas_audio_in == n_edges[0]) else report_fail("output did not return to the player");
		end_test("adc source");

		$display("Tests: %0d run, %0d failed, %0d check errors", n_tests, n_failed, err_cnt);
		if (err_cnt == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/msx_tape_top.sv
// Cassette path top level: clock enables, tape control, image RAM, player and audio output mux
`default_nettype none

module msx_tape_top #(
	parameter int HALF_SHORT = msx_tape_pkg::HALF_SHORT_DEF
) (
	input  logic        CLK_VIDEO,
	input  logic        rst_n,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  logic        ioctl_wr,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	input  logic        status_src_adc,
	input  logic        status_rewind,
	input  logic        motor,
	input  logic        adc_bit,
	input  logic        adc_active,
	output logic        ce_10m7,
	output logic        ce_5m3,
	output logic        cas_audio_in,
	output logic        playing
);

	import msx_tape_pkg::*;

	cas_addr_t  ram_addr;
	cas_addr_t  player_addr;
	cas_addr_t  image_len;
	logic       ram_wren;
	logic [7:0] ram_data;
	logic [7:0] ram_q;
	logic       rewind;
	logic       src_adc;
	logic       cas_out;

	////////////////////////////////////////////////////////////
	// Host download bus, loader side driven from the pins
	////////////////////////////////////////////////////////////

	ioctl_if host ();

	assign host.download = ioctl_download;
	assign host.index    = ioctl_index;
	assign host.wr       = ioctl_wr;
	assign host.addr     = ioctl_addr;
	assign host.dout     = ioctl_dout;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	clock_enables i_clock_enables (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.ce_10m7   (ce_10m7),
		.ce_5m3    (ce_5m3)
	);

	tape_control i_tape_control (
		.CLK_VIDEO      (CLK_VIDEO),
		.rst_n          (rst_n),
		.host           (host.sink),
		.status_src_adc (status_src_adc),
		.status_rewind  (status_rewind),
		.player_addr    (player_addr),
		.ram_addr       (ram_addr),
		.ram_wren       (ram_wren),
		.ram_data       (ram_data),
		.image_len      (image_len),
		.rewind         (rewind),
		.src_adc        (src_adc)
	);

	cas_ram i_cas_ram (
		.CLK_VIDEO (CLK_VIDEO),
		.addr      (ram_addr),
		.wren      (ram_wren),
		.data      (ram_data),
		.q         (ram_q)
	);

	cas_player #(
		.HALF_SHORT (HALF_SHORT)
	) i_cas_player (
		.CLK_VIDEO (CLK_VIDEO),
		.rst_n     (rst_n),
		.ce_5m3    (ce_5m3),
		.motor     (motor),
		.rewind    (rewind),
		.image_len (image_len),
		.ram_addr  (player_addr),
		.ram_q     (ram_q),
		.cas_out   (cas_out),
		.playing   (playing)
	);

	// Cassette input to the computer
	// ADC bit counts only while the ADC reports activity
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n)
			cas_audio_in <= 1'b0;
		else
			cas_audio_in <= src_adc ? (adc_bit && adc_active) : cas_out;
	end

endmodule

`default_nettype wire

//--- hw/cas_player.sv
// CAS player: fetches image bytes and generates the framed two-tone cassette waveform
`default_nettype none

module cas_player #(
	parameter int HALF_SHORT = msx_tape_pkg::HALF_SHORT_DEF
) (
	input  logic                    CLK_VIDEO,
	input  logic                    rst_n,
	input  logic                    ce_5m3,
	input  logic                    motor,
	input  logic                    rewind,
	input  msx_tape_pkg::cas_addr_t image_len,
	output msx_tape_pkg::cas_addr_t ram_addr,
	input  logic [7:0]              ram_q,
	output logic                    cas_out,
	output logic                    playing
);

	import msx_tape_pkg::*;

	// Tick counter width, safe down to HALF_SHORT of 1
	localparam int TICK_W = $clog2(HALF_SHORT + 1);
	localparam int HALF_W = $clog2(BIT_HALVES);
	// Start bit, eight data bits, stop bits
	localparam int FRAME_LAST = 8 + STOP_BITS;

	cas_addr_t         addr;
	logic [TICK_W-1:0] tick_cnt;
	logic [HALF_W-1:0] half_cnt;
	logic [3:0]        frame;
	logic [7:0]        sh;
	logic              done;
	logic              cur_bit;
	logic              half_end;
	logic              bit_end;
	logic              last_byte;
	logic              step;

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////

	// More to play while the byte pointer is inside the image
	// A zero length never passes this compare
	assign playing   = !done && (addr < image_len);
	assign step      = ce_5m3 && motor && playing;
	assign half_end  = (tick_cnt == TICK_W'(HALF_SHORT - 1));
	assign bit_end   = (half_cnt == HALF_W'(BIT_HALVES - 1));
	assign last_byte = !(({1'b0, addr} + 19'd1) < {1'b0, image_len});

	// Start bit is 0, stop bits are 1, data goes LSB first
	always_comb begin
		if (frame == 4'd0)
			cur_bit = 1'b0;
		else if (frame <= 4'd8)
			cur_bit = sh[0];
		else
			cur_bit = 1'b1;
	end

	// Next byte is read ahead during the final stop bit
	assign ram_addr = ((frame == 4'(FRAME_LAST)) && !last_byte) ? addr + 1'b1 : addr;

	////////////////////////////////////////////////////////////
	// Bit and byte sequencer
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			addr     <= '0;
			tick_cnt <= '0;
			half_cnt <= '0;
			frame    <= '0;
			done     <= 1'b0;
			cas_out  <= 1'b0;
		end else if (rewind) begin
			// Back to the start bit of byte 0, level low
			addr     <= '0;
			tick_cnt <= '0;
			half_cnt <= '0;
			frame    <= '0;
			done     <= 1'b0;
			cas_out  <= 1'b0;
		end else if (step) begin
			if (!half_end) begin
				tick_cnt <= tick_cnt + 1'b1;
			end else begin
				tick_cnt <= '0;
				// High tone flips every half-period, low tone every other one
				if (cur_bit || half_cnt[0])
					cas_out <= !cas_out;
				if (!bit_end) begin
					half_cnt <= half_cnt + 1'b1;
				end else begin
					half_cnt <= '0;
					if (frame == 4'(FRAME_LAST)) begin
						frame <= '0;
						// Last stop bit of the image ends playback
						if (last_byte)
							done <= 1'b1;
						else
							addr <= addr + 1'b1;
					end else begin
						frame <= frame + 1'b1;
					end
				end
			end
		end
	end

	// Byte shift register, payload only
	// Loaded as the start bit ends, shifted after each data bit
	always_ff @(posedge CLK_VIDEO) begin
		if (step && half_end && bit_end) begin
			if (frame == 4'd0)
				sh <= ram_q;
			else if (frame <= 4'd8)
				sh <= {1'b0, sh[7:1]};
		end
	end

	// Read address stays inside the image while the tape runs
	a_addr_in_image: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		playing |-> (ram_addr < image_len));

endmodule

`default_nettype wire

//--- hw/cas_ram.sv
// Single-port synchronous RAM holding the CAS tape image
`default_nettype none

module cas_ram (
	input  logic                    CLK_VIDEO,
	input  msx_tape_pkg::cas_addr_t addr,
	input  logic                    wren,
	input  logic [7:0]              data,
	output logic [7:0]              q
);

	import msx_tape_pkg::*;

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	// One byte per image position
	logic [7:0] mem [CAS_DEPTH];

	// Write port
	always_ff @(posedge CLK_VIDEO) begin
		if (wren)
			mem[addr] <= data;
	end

	// Registered read, one cycle after the address
	// Old contents come out on a write to the same address
	always_ff @(posedge CLK_VIDEO) begin
		q <= mem[addr];
	end

endmodule

`default_nettype wire

//--- hw/tape_control.sv
// Tape configuration block with status latches, CAS download decode, RAM routing, image length and rewind
`default_nettype none

module tape_control (
	input  logic                   CLK_VIDEO,
	input  logic                   rst_n,
	ioctl_if.sink                  host,
	input  logic                   status_src_adc,
	input  logic                   status_rewind,
	input  msx_tape_pkg::cas_addr_t player_addr,
	output msx_tape_pkg::cas_addr_t ram_addr,
	output logic                   ram_wren,
	output logic [7:0]             ram_data,
	output msx_tape_pkg::cas_addr_t image_len,
	output logic                   rewind,
	output logic                   src_adc
);

	import msx_tape_pkg::*;

	logic            is_cas;
	logic            cas_q;
	logic            cas_start;
	logic            rew_q;
	logic [18:0]     wr_end;
	logic [18:0]     len_base;

	////////////////////////////////////////////////////////////
	// Download decode and RAM routing
	////////////////////////////////////////////////////////////

	// CAS image coming in from the host
	assign is_cas    = host.download && (host.index[5:0] == CAS_INDEX);
	assign cas_start = is_cas && !cas_q;

	// Host owns the RAM during a CAS download and the player at other times
	assign ram_addr = is_cas ? host.addr[17:0] : player_addr;
	assign ram_wren = host.wr && is_cas;
	assign ram_data = host.dout;

	// One past the written byte
	assign wr_end   = {1'b0, host.addr[17:0]} + 19'd1;
	// Length starts over on a new download
	assign len_base = cas_start ? 19'd0 : {1'b0, image_len};

	////////////////////////////////////////////////////////////
	// Registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			cas_q     <= 1'b0;
			rew_q     <= 1'b0;
			src_adc   <= 1'b0;
			rewind    <= 1'b0;
			image_len <= '0;
		end else begin
			cas_q   <= is_cas;
			rew_q   <= status_rewind;
			// Menu source select
			src_adc <= status_src_adc;
			// Single pulse on menu rewind or on a new image
			rewind  <= ((status_rewind && !rew_q) || cas_start) && !rewind;
			// Track the highest written byte
			if (ram_wren && (wr_end > len_base))
				image_len <= wr_end[17:0];
			else
				image_len <= len_base[17:0];
		end
	end

	// Rewind never stretches over two cycles
	a_rewind_pulse: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		rewind |=> !rewind);

endmodule

`default_nettype wire

//--- hw/clock_enables.sv
// Clock enable divider making the 10.7 MHz and 5.3 MHz strobes from CLK_VIDEO
`default_nettype none

module clock_enables (
	input  logic CLK_VIDEO,
	input  logic rst_n,
	output logic ce_10m7,
	output logic ce_5m3
);

	import msx_tape_pkg::*;

	// Divider width, CE_DIV is a power of two
	localparam int DIV_W = $clog2(CE_DIV);

	logic [DIV_W-1:0] div;

	// Free running divider
	// Both strobes are registered so they leave the block glitch free
	always_ff @(posedge CLK_VIDEO or negedge rst_n) begin
		if (!rst_n) begin
			div     <= '0;
			ce_10m7 <= 1'b0;
			ce_5m3  <= 1'b0;
		end else begin
			div     <= div + 1'b1;
			// Half the divider period
			ce_10m7 <= (div[DIV_W-2:0] == '0);
			// Full divider period, lands on a ce_10m7 cycle
			ce_5m3  <= (div == '0);
		end
	end

	// Slow strobe must always sit on a fast strobe
	a_ce_nested: assert property (@(posedge CLK_VIDEO) disable iff (!rst_n)
		ce_5m3 |-> ce_10m7);

endmodule

`default_nettype wire

//--- hw/ioctl_if.sv
// Host download bus interface with loader and sink modports
`default_nettype none

interface ioctl_if;

	// Download in progress
	logic        download;
	// File index chosen in the menu
	logic [7:0]  index;
	// Write strobe, one byte per pulse, no wait
	logic        wr;
	// Byte offset inside the file
	logic [24:0] addr;
	// Byte being written
	logic [7:0]  dout;

	// Side that streams the file in
	modport loader (
		output download,
		output index,
		output wr,
		output addr,
		output dout
	);

	// Side that stores the bytes
	modport sink (
		input download,
		input index,
		input wr,
		input addr,
		input dout
	);

endinterface

`default_nettype wire

//--- hw/msx_tape_pkg.sv
// Tape image types, cassette timing constants and download index for the MSX tape path
`default_nettype none

package msx_tape_pkg;

	////////////////////////////////////////////////////////////
	// Image storage
	////////////////////////////////////////////////////////////

	// Byte address into the CAS image, 256 KiB max
	typedef logic [17:0] cas_addr_t;

	// Number of bytes the image RAM holds
	localparam int CAS_DEPTH = 262144;

	// Download index of a CAS image
	// Only the low six bits of the host index are decoded
	localparam logic [5:0] CAS_INDEX = 6'd2;

	////////////////////////////////////////////////////////////
	// Cassette waveform timing
	////////////////////////////////////////////////////////////

	// High tone half-period in ce_5m3 ticks, about 2400 Hz
	// Low tone half-period is twice this
	localparam int HALF_SHORT_DEF = 1118;

	// High tone half-periods in one bit cell
	localparam int BIT_HALVES = 4;

	// Stop bits after the eight data bits
	localparam int STOP_BITS = 2;

	// CLK_VIDEO cycles between two ce_5m3 strobes
	localparam int CE_DIV = 8;

endpackage

`default_nettype wire
